// File: core_mem_pkg.sv
// Shared sizes, widths and address types of the core memory region.
// Modules pull this in with a wildcard import in their body and use
// scoped names in their port lists.

`default_nettype none

package core_mem_pkg;

  // wide RAM words, as seen by the loader ports
  localparam int WIDE_W    = 64;
  localparam int WIDE_BE_W = WIDE_W / 8;

  // core side data and address width
  localparam int CORE_W    = 32;
  localparam int CORE_BE_W = CORE_W / 8;

  // memory sizes in bytes
  localparam int INSTR_RAM_BYTES = 32768;
  localparam int DATA_RAM_BYTES  = 16384;

  // byte address bits of each RAM
  localparam int INSTR_ADDR_W = $clog2(INSTR_RAM_BYTES);
  localparam int DATA_ADDR_W  = $clog2(DATA_RAM_BYTES);

  typedef logic [INSTR_ADDR_W-1:0] instr_addr_t;
  typedef logic [DATA_ADDR_W-1:0]  data_addr_t;

  // byte offset inside one wide word
  localparam int WORD_OFS_W = $clog2(WIDE_BE_W);

  // load/store page that maps onto the data RAM, compared with addr[31:20]
  localparam logic [11:0] LOCAL_PAGE = 12'h001;

  // interrupt lines and encoded id
  localparam int IRQ_N    = 32;
  localparam int IRQ_ID_W = $clog2(IRQ_N);

endpackage

`default_nettype wire

// File: irq_id_encoder.sv
// Interrupt line encoder. Collapses the interrupt lines into one request
// bit and the index of the highest active line. Purely combinational.

`timescale 1ns/1ps
`default_nettype none

module irq_id_encoder (
  input  wire logic [core_mem_pkg::IRQ_N-1:0]    irq_i,
  output logic                                   irq_o,
  output logic      [core_mem_pkg::IRQ_ID_W-1:0] irq_id_o
);

  import core_mem_pkg::*;

  assign irq_o = |irq_i;

  // later lines overwrite earlier ones, so the highest index wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < IRQ_N; i++) begin
      if (irq_i[i]) begin
        irq_id_o = IRQ_ID_W'(i);
      end
    end
  end

endmodule

`default_nettype wire

// File: sp_ram.sv
// Single-port synchronous RAM of wide words with byte enables.
// Read data is registered and valid one cycle after an enabled read;
// it holds its value while the RAM is idle or writing.

`timescale 1ns/1ps
`default_nettype none

module sp_ram #(
  parameter int WORDS = 2048
) (
  input  wire logic                                clk,
  input  wire logic                                en_i,
  input  wire logic [$clog2(WORDS)-1:0]            addr_i,
  input  wire logic                                we_i,
  input  wire logic [core_mem_pkg::WIDE_BE_W-1:0]  be_i,
  input  wire logic [core_mem_pkg::WIDE_W-1:0]     wdata_i,
  output logic      [core_mem_pkg::WIDE_W-1:0]     rdata_o
);

  import core_mem_pkg::*;

  logic [WIDE_W-1:0] mem [WORDS];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        // only the enabled bytes change
        for (int b = 0; b < WIDE_BE_W; b++) begin
          if (be_i[b]) begin
            mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: ram_port_mux.sv
// Shares one wide RAM between a loader port and a 32-bit core port.
// The loader has fixed priority and no grant; the core is granted
// combinationally when the loader is idle and gets rvalid one cycle later.
// The address type sets the RAM depth, so one module serves both RAMs.

`timescale 1ns/1ps
`default_nettype none

module ram_port_mux #(
  parameter type addr_t = logic [core_mem_pkg::DATA_ADDR_W-1:0]
) (
  input  wire logic                                clk,
  input  wire logic                                rst_n,

  // loader side
  input  wire logic                                load_req_i,
  input  wire addr_t                               load_addr_i,
  input  wire logic                                load_we_i,
  input  wire logic [core_mem_pkg::WIDE_BE_W-1:0]  load_be_i,
  input  wire logic [core_mem_pkg::WIDE_W-1:0]     load_wdata_i,
  output logic      [core_mem_pkg::WIDE_W-1:0]     load_rdata_o,

  // core side
  input  wire logic                                core_req_i,
  input  wire addr_t                               core_addr_i,
  input  wire logic                                core_we_i,
  input  wire logic [core_mem_pkg::CORE_BE_W-1:0]  core_be_i,
  input  wire logic [core_mem_pkg::CORE_W-1:0]     core_wdata_i,
  output logic                                     core_gnt_o,
  output logic                                     core_rvalid_o,
  output logic      [core_mem_pkg::CORE_W-1:0]     core_rdata_o
);

  import core_mem_pkg::*;

  localparam int ADDR_W = $bits(addr_t);
  localparam int RAM_AW = ADDR_W - WORD_OFS_W;
  localparam int WORDS  = 2 ** RAM_AW;

  logic                 ram_en;
  logic [RAM_AW-1:0]    ram_addr;
  logic                 ram_we;
  logic [WIDE_BE_W-1:0] ram_be;
  logic [WIDE_W-1:0]    ram_wdata;
  logic [WIDE_W-1:0]    ram_rdata;
  logic [WIDE_BE_W-1:0] core_be_wide;
  logic                 core_half;
  logic                 half_q;
  logic                 rvalid_q;

  // address bit 2 picks the upper or lower 32-bit half
  assign core_half    = core_addr_i[WORD_OFS_W-1];
  assign core_be_wide = core_half ? {core_be_i, {CORE_BE_W{1'b0}}}
                                  : {{CORE_BE_W{1'b0}}, core_be_i};

  assign core_gnt_o = core_req_i & ~load_req_i;

  // loader wins whenever it requests
  always_comb begin
    ram_en = load_req_i | core_req_i;
    if (load_req_i) begin
      ram_addr  = load_addr_i[ADDR_W-1:WORD_OFS_W];
      ram_we    = load_we_i;
      ram_be    = load_be_i;
      ram_wdata = load_wdata_i;
    end else begin
      ram_addr  = core_addr_i[ADDR_W-1:WORD_OFS_W];
      ram_we    = core_we_i;
      ram_be    = core_be_wide;
      ram_wdata = {2{core_wdata_i}};
    end
  end

  sp_ram #(
    .WORDS   ( WORDS     )
  ) ram_i (
    .clk     ( clk       ),
    .en_i    ( ram_en    ),
    .addr_i  ( ram_addr  ),
    .we_i    ( ram_we    ),
    .be_i    ( ram_be    ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

  // remember which half goes back with the core response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
      half_q   <= 1'b0;
    end else begin
      rvalid_q <= core_gnt_o;
      if (core_gnt_o) begin
        half_q <= core_half;
      end
    end
  end

  assign core_rvalid_o = rvalid_q;
  assign core_rdata_o  = half_q ? ram_rdata[WIDE_W-1:CORE_W] : ram_rdata[CORE_W-1:0];
  assign load_rdata_o  = ram_rdata;

endmodule

`default_nettype wire

// File: lsu_demux.sv
// Load/store request router. Requests in the local page go to the data
// RAM port, all others to the external port. A one-bit register keeps
// track of which side returns the next response.

`timescale 1ns/1ps
`default_nettype none

module lsu_demux (
  input  wire logic                             clk,
  input  wire logic                             rst_n,

  // load/store master side
  input  wire logic                             lsu_req_i,
  input  wire logic [core_mem_pkg::CORE_W-1:0]  lsu_addr_i,
  output logic                                  lsu_gnt_o,
  output logic                                  lsu_rvalid_o,
  output logic      [core_mem_pkg::CORE_W-1:0]  lsu_rdata_o,

  // data RAM side
  output logic                                  local_req_o,
  input  wire logic                             local_gnt_i,
  input  wire logic                             local_rvalid_i,
  input  wire logic [core_mem_pkg::CORE_W-1:0]  local_rdata_i,

  // external side
  output logic                                  ext_req_o,
  input  wire logic                             ext_gnt_i,
  input  wire logic                             ext_rvalid_i,
  input  wire logic [core_mem_pkg::CORE_W-1:0]  ext_rdata_i
);

  import core_mem_pkg::*;

  logic is_local;
  logic resp_ext_q;

  assign is_local = (lsu_addr_i[CORE_W-1:CORE_W-12] == LOCAL_PAGE);

  assign local_req_o = lsu_req_i &  is_local;
  assign ext_req_o   = lsu_req_i & ~is_local;

  // grant comes from whichever side got the request
  always_comb begin
    lsu_gnt_o = 1'b0;
    if (ext_req_o) begin
      lsu_gnt_o = ext_gnt_i;
    end else if (local_req_o) begin
      lsu_gnt_o = local_gnt_i;
    end
  end

  // response source starts at local after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_ext_q <= 1'b0;
    end else if (lsu_req_i) begin
      resp_ext_q <= ~is_local;
    end
  end

  assign lsu_rdata_o  = resp_ext_q ? ext_rdata_i : local_rdata_i;
  assign lsu_rvalid_o = local_rvalid_i | ext_rvalid_i;

endmodule

`default_nettype wire

// File: core_mem_region.sv
// Memory side of the core region: instruction and data RAM, each shared
// between a wide loader port and a core port, the load/store address
// router with its external port, and the interrupt encoder.
// The fetch and load/store ports are driven from outside.

`timescale 1ns/1ps
`default_nettype none

module core_mem_region (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,

  // instruction fetch
  input  wire logic                                 fetch_req_i,
  input  wire logic [core_mem_pkg::CORE_W-1:0]      fetch_addr_i,
  output logic                                      fetch_gnt_o,
  output logic                                      fetch_rvalid_o,
  output logic      [core_mem_pkg::CORE_W-1:0]      fetch_rdata_o,

  // load/store
  input  wire logic                                 lsu_req_i,
  input  wire logic [core_mem_pkg::CORE_W-1:0]      lsu_addr_i,
  input  wire logic                                 lsu_we_i,
  input  wire logic [core_mem_pkg::CORE_BE_W-1:0]   lsu_be_i,
  input  wire logic [core_mem_pkg::CORE_W-1:0]      lsu_wdata_i,
  output logic                                      lsu_gnt_o,
  output logic                                      lsu_rvalid_o,
  output logic      [core_mem_pkg::CORE_W-1:0]      lsu_rdata_o,

  // external request port
  output logic                                      ext_req_o,
  output logic      [core_mem_pkg::CORE_W-1:0]      ext_addr_o,
  output logic                                      ext_we_o,
  output logic      [core_mem_pkg::CORE_BE_W-1:0]   ext_be_o,
  output logic      [core_mem_pkg::CORE_W-1:0]      ext_wdata_o,
  input  wire logic                                 ext_gnt_i,
  input  wire logic                                 ext_rvalid_i,
  input  wire logic [core_mem_pkg::CORE_W-1:0]      ext_rdata_i,

  // instruction RAM loader
  input  wire logic                                 iload_req_i,
  input  wire core_mem_pkg::instr_addr_t            iload_addr_i,
  input  wire logic                                 iload_we_i,
  input  wire logic [core_mem_pkg::WIDE_BE_W-1:0]   iload_be_i,
  input  wire logic [core_mem_pkg::WIDE_W-1:0]      iload_wdata_i,
  output logic      [core_mem_pkg::WIDE_W-1:0]      iload_rdata_o,

  // data RAM loader
  input  wire logic                                 dload_req_i,
  input  wire core_mem_pkg::data_addr_t             dload_addr_i,
  input  wire logic                                 dload_we_i,
  input  wire logic [core_mem_pkg::WIDE_BE_W-1:0]   dload_be_i,
  input  wire logic [core_mem_pkg::WIDE_W-1:0]      dload_wdata_i,
  output logic      [core_mem_pkg::WIDE_W-1:0]      dload_rdata_o,

  // interrupts
  input  wire logic [core_mem_pkg::IRQ_N-1:0]       irq_i,
  output logic                                      irq_o,
  output logic      [core_mem_pkg::IRQ_ID_W-1:0]    irq_id_o
);

  import core_mem_pkg::*;

  // local load/store path into the data RAM
  logic              data_req;
  logic              data_gnt;
  logic              data_rvalid;
  logic [CORE_W-1:0] data_rdata;

  // request payload goes out unchanged
  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  lsu_demux lsu_demux_i (
    .clk            ( clk          ),
    .rst_n          ( rst_n        ),
    .lsu_req_i      ( lsu_req_i    ),
    .lsu_addr_i     ( lsu_addr_i   ),
    .lsu_gnt_o      ( lsu_gnt_o    ),
    .lsu_rvalid_o   ( lsu_rvalid_o ),
    .lsu_rdata_o    ( lsu_rdata_o  ),
    .local_req_o    ( data_req     ),
    .local_gnt_i    ( data_gnt     ),
    .local_rvalid_i ( data_rvalid  ),
    .local_rdata_i  ( data_rdata   ),
    .ext_req_o      ( ext_req_o    ),
    .ext_gnt_i      ( ext_gnt_i    ),
    .ext_rvalid_i   ( ext_rvalid_i ),
    .ext_rdata_i    ( ext_rdata_i  )
  );

  // fetch is read only
  ram_port_mux #(
    .addr_t        ( instr_addr_t                     )
  ) instr_mux_i (
    .clk           ( clk                              ),
    .rst_n         ( rst_n                            ),
    .load_req_i    ( iload_req_i                      ),
    .load_addr_i   ( iload_addr_i                     ),
    .load_we_i     ( iload_we_i                       ),
    .load_be_i     ( iload_be_i                       ),
    .load_wdata_i  ( iload_wdata_i                    ),
    .load_rdata_o  ( iload_rdata_o                    ),
    .core_req_i    ( fetch_req_i                      ),
    .core_addr_i   ( fetch_addr_i[INSTR_ADDR_W-1:0]   ),
    .core_we_i     ( 1'b0                             ),
    .core_be_i     ( {CORE_BE_W{1'b1}}                ),
    .core_wdata_i  ( {CORE_W{1'b0}}                   ),
    .core_gnt_o    ( fetch_gnt_o                      ),
    .core_rvalid_o ( fetch_rvalid_o                   ),
    .core_rdata_o  ( fetch_rdata_o                    )
  );

  ram_port_mux #(
    .addr_t        ( data_addr_t                      )
  ) data_mux_i (
    .clk           ( clk                              ),
    .rst_n         ( rst_n                            ),
    .load_req_i    ( dload_req_i                      ),
    .load_addr_i   ( dload_addr_i                     ),
    .load_we_i     ( dload_we_i                       ),
    .load_be_i     ( dload_be_i                       ),
    .load_wdata_i  ( dload_wdata_i                    ),
    .load_rdata_o  ( dload_rdata_o                    ),
    .core_req_i    ( data_req                         ),
    .core_addr_i   ( lsu_addr_i[DATA_ADDR_W-1:0]      ),
    .core_we_i     ( lsu_we_i                         ),
    .core_be_i     ( lsu_be_i                         ),
    .core_wdata_i  ( lsu_wdata_i                      ),
    .core_gnt_o    ( data_gnt                         ),
    .core_rvalid_o ( data_rvalid                      ),
    .core_rdata_o  ( data_rdata                       )
  );

  irq_id_encoder irq_enc_i (
    .irq_i    ( irq_i    ),
    .irq_o    ( irq_o    ),
    .irq_id_o ( irq_id_o )
  );

endmodule

`default_nettype wire

// File: ram_port_mux_props.sv
// Protocol assertions for the RAM port mux, bound into every instance.
// Checks the loader priority and the one-cycle rvalid timing.

`timescale 1ns/1ps
`default_nettype none

module ram_port_mux_props (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic load_req_i,
  input wire logic core_req_i,
  input wire logic core_gnt_o,
  input wire logic core_rvalid_o
);

  // loader always wins
  gnt_not_with_load: assert property (@(posedge clk) disable iff (!rst_n)
    core_gnt_o |-> !load_req_i)
    else $error("core granted while loader requests");

  gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    core_gnt_o |-> core_req_i)
    else $error("core granted without a request");

  rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    core_gnt_o |=> core_rvalid_o)
    else $error("rvalid missing one cycle after grant");

  rvalid_only_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    !core_gnt_o |=> !core_rvalid_o)
    else $error("rvalid without a grant in the previous cycle");

endmodule

bind ram_port_mux ram_port_mux_props props_i (
  .clk           ( clk           ),
  .rst_n         ( rst_n         ),
  .load_req_i    ( load_req_i    ),
  .core_req_i    ( core_req_i    ),
  .core_gnt_o    ( core_gnt_o    ),
  .core_rvalid_o ( core_rvalid_o )
);

`default_nettype wire

// File: tb_checker.sv
// Watches the memory region ports, keeps shadow images of both RAMs and
// compares every response against the expected value. Error counts are
// handed back to the testbench top.

`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  wire logic        clk, rst_n,
  input  wire logic        fetch_req_i, fetch_gnt_o, fetch_rvalid_o,
  input  wire logic [31:0] fetch_addr_i, fetch_rdata_o,
  input  wire logic        lsu_req_i, lsu_we_i, lsu_gnt_o, lsu_rvalid_o,
  input  wire logic [3:0]  lsu_be_i, ext_be_o,
  input  wire logic [31:0] lsu_addr_i, lsu_wdata_i, lsu_rdata_o,
  input  wire logic        ext_req_o, ext_we_o, ext_gnt_i,
  input  wire logic [31:0] ext_addr_o, ext_wdata_o,
  input  wire logic        iload_req_i, iload_we_i, dload_req_i, dload_we_i,
  input  wire logic [14:0] iload_addr_i,
  input  wire logic [13:0] dload_addr_i,
  input  wire logic [7:0]  iload_be_i, dload_be_i,
  input  wire logic [63:0] iload_wdata_i, iload_rdata_o, dload_wdata_i, dload_rdata_o,
  input  wire logic [31:0] irq_i,
  input  wire logic        irq_o,
  input  wire logic [4:0]  irq_id_o,
  output int               data_errs,
  output int               proto_errs
);

  import core_mem_pkg::*;

  logic [WIDE_W-1:0] shadow_i [INSTR_RAM_BYTES/8];
  logic [WIDE_W-1:0] shadow_d [DATA_RAM_BYTES/8];
  logic [CORE_W-1:0] fetch_q [$];
  // write flag on top of the expected read data
  logic [CORE_W:0]   lsu_q [$];
  logic              fetch_gnt_d, local_gnt_d, iload_rd_d, dload_rd_d;
  logic [WIDE_W-1:0] iload_want, dload_want;

  function automatic logic [CORE_W-1:0] pick_half(logic [WIDE_W-1:0] w, logic hi);
    return hi ? w[WIDE_W-1:CORE_W] : w[CORE_W-1:0];
  endfunction

  function automatic logic [WIDE_W-1:0] merge_bytes(logic [WIDE_W-1:0] old,
                                                    logic [WIDE_W-1:0] wdata,
                                                    logic [WIDE_BE_W-1:0] be);
    logic [WIDE_W-1:0] res;
    res = old;
    for (int b = 0; b < WIDE_BE_W; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // external slave answers with the inverted address
  function automatic logic [CORE_W-1:0] ext_reply(logic [CORE_W-1:0] addr);
    return ~addr;
  endfunction

  function automatic logic [IRQ_ID_W-1:0] highest_irq(logic [IRQ_N-1:0] lines);
    for (int i = IRQ_N - 1; i >= 0; i--) begin
      if (lines[i]) begin
        return IRQ_ID_W'(i);
      end
    end
    return '0;
  endfunction

  task automatic report_value(string name, logic [63:0] want, logic [63:0] got);
    $display("Fail %s: expected %h, actual %h", name, want, got);
    data_errs++;
  endtask

  task automatic report_proto(string msg);
    $display("%s at %0t", msg, $time);
    proto_errs++;
  endtask

  initial begin
    data_errs  = 0;
    proto_errs = 0;
  end

  always @(posedge clk) begin
    logic              is_local;
    logic              hi;
    logic              want_fetch_gnt;
    logic              want_lsu_gnt;
    logic [CORE_W:0]   ent;
    logic [CORE_W-1:0] want;
    is_local       = (lsu_addr_i[31:20] == LOCAL_PAGE);
    hi             = lsu_addr_i[2];
    want_fetch_gnt = fetch_req_i && !iload_req_i;
    want_lsu_gnt   = lsu_req_i && (is_local ? !dload_req_i : ext_gnt_i);
    if (!rst_n) begin
      fetch_gnt_d = 1'b0;
      local_gnt_d = 1'b0;
      iload_rd_d  = 1'b0;
      dload_rd_d  = 1'b0;
      fetch_q.delete();
      lsu_q.delete();
    end else begin
      // responses to requests of the previous cycle
      if (fetch_rvalid_o) begin
        if (!fetch_gnt_d || fetch_q.size() == 0) begin
          report_proto("fetch rvalid without a granted fetch");
        end else begin
          want = fetch_q.pop_front();
          if (fetch_rdata_o !== want) begin
            report_value("fetch", 64'(want), 64'(fetch_rdata_o));
          end
        end
      end else if (fetch_gnt_d) begin
        report_proto("fetch rvalid missing one cycle after grant");
        void'(fetch_q.pop_front());
      end
      if (lsu_rvalid_o) begin
        if (lsu_q.size() == 0) begin
          report_proto("load/store rvalid with nothing outstanding");
        end else begin
          ent = lsu_q.pop_front();
          if (!ent[CORE_W] && lsu_rdata_o !== ent[CORE_W-1:0]) begin
            report_value("load/store read", 64'(ent[CORE_W-1:0]), 64'(lsu_rdata_o));
          end
        end
      end else if (local_gnt_d) begin
        report_proto("load/store rvalid missing one cycle after local grant");
        void'(lsu_q.pop_front());
      end
      if (iload_rd_d && iload_rdata_o !== iload_want) begin
        report_value("iload read", iload_want, iload_rdata_o);
      end
      if (dload_rd_d && dload_rdata_o !== dload_want) begin
        report_value("dload read", dload_want, dload_rdata_o);
      end

      // port rules that hold in every cycle
      if (fetch_gnt_o !== want_fetch_gnt) begin
        report_value("fetch grant", 64'(want_fetch_gnt), 64'(fetch_gnt_o));
      end
      if (lsu_gnt_o !== want_lsu_gnt) begin
        report_value("load/store grant", 64'(want_lsu_gnt), 64'(lsu_gnt_o));
      end
      if (ext_req_o !== (lsu_req_i && !is_local)) begin
        report_proto("ext_req_o does not follow the non-local request");
      end
      if (ext_req_o && ext_addr_o !== lsu_addr_i) begin
        report_value("ext addr", 64'(lsu_addr_i), 64'(ext_addr_o));
      end
      if (ext_req_o && {ext_we_o, ext_be_o, ext_wdata_o} !== {lsu_we_i, lsu_be_i, lsu_wdata_i}) begin
        report_value("ext payload", 64'({lsu_we_i, lsu_be_i, lsu_wdata_i}),
                     64'({ext_we_o, ext_be_o, ext_wdata_o}));
      end
      if (irq_o !== (|irq_i)) begin
        report_value("irq", 64'(|irq_i), 64'(irq_o));
      end
      if (irq_id_o !== highest_irq(irq_i)) begin
        report_value("irq id", 64'(highest_irq(irq_i)), 64'(irq_id_o));
      end

      // loader accesses
      iload_rd_d = iload_req_i && !iload_we_i;
      if (iload_req_i) begin
        if (iload_we_i) begin
          shadow_i[iload_addr_i[14:3]] = merge_bytes(shadow_i[iload_addr_i[14:3]],
                                                     iload_wdata_i, iload_be_i);
        end
        iload_want = shadow_i[iload_addr_i[14:3]];
      end
      dload_rd_d = dload_req_i && !dload_we_i;
      if (dload_req_i) begin
        if (dload_we_i) begin
          shadow_d[dload_addr_i[13:3]] = merge_bytes(shadow_d[dload_addr_i[13:3]],
                                                     dload_wdata_i, dload_be_i);
        end
        dload_want = shadow_d[dload_addr_i[13:3]];
      end

      // granted core accesses
      fetch_gnt_d = fetch_req_i && fetch_gnt_o;
      if (fetch_gnt_d) begin
        fetch_q.push_back(pick_half(shadow_i[fetch_addr_i[14:3]], fetch_addr_i[2]));
      end
      local_gnt_d = lsu_req_i && lsu_gnt_o && is_local;
      if (lsu_req_i && lsu_gnt_o) begin
        if (is_local) begin
          if (lsu_we_i) begin
            shadow_d[lsu_addr_i[13:3]] = merge_bytes(shadow_d[lsu_addr_i[13:3]],
                                                     {2{lsu_wdata_i}},
                                                     hi ? {lsu_be_i, 4'b0} : {4'b0, lsu_be_i});
          end
          lsu_q.push_back({lsu_we_i, pick_half(shadow_d[lsu_addr_i[13:3]], hi)});
        end else begin
          lsu_q.push_back({lsu_we_i, ext_reply(lsu_addr_i)});
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_core_mem_region.sv
// Testbench top for the core memory region. Generates clock and reset,
// drives fetch, load/store, loader and interrupt stimulus, models the
// external slave and stops the run on a cycle limit.

`timescale 1ns/1ps
`default_nettype none

module tb_core_mem_region;

  import core_mem_pkg::*;

  localparam logic [31:0] LFSR_SEED      = 32'he525;
  localparam int          FETCH_WORDS    = 16;
  localparam int          LSU_OPS        = 32;
  localparam int          EXT_OPS        = 32;
  localparam int          IRQ_CYCLES     = 64;
  localparam int          TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] LOCAL_BASE     = {LOCAL_PAGE, 20'h0};

  logic clk, rst_n;
  logic fetch_req_i, fetch_gnt_o, fetch_rvalid_o;
  logic [31:0] fetch_addr_i, fetch_rdata_o;
  logic lsu_req_i, lsu_we_i, lsu_gnt_o, lsu_rvalid_o;
  logic [3:0] lsu_be_i, ext_be_o;
  logic [31:0] lsu_addr_i, lsu_wdata_i, lsu_rdata_o;
  logic ext_req_o, ext_we_o, ext_gnt_i, ext_rvalid_i;
  logic [31:0] ext_addr_o, ext_wdata_o, ext_rdata_i;
  logic iload_req_i, iload_we_i, dload_req_i, dload_we_i;
  instr_addr_t iload_addr_i;
  data_addr_t dload_addr_i;
  logic [7:0] iload_be_i, dload_be_i;
  logic [63:0] iload_wdata_i, iload_rdata_o, dload_wdata_i, dload_rdata_o;
  logic [31:0] irq_i;
  logic irq_o;
  logic [4:0] irq_id_o;
  int data_errs, proto_errs;
  int cycle_cnt;
  logic [31:0] lfsr_q;
  logic [31:0] r, a;
  logic [31:0] w;

  core_mem_region core_mem_region_i (.*);
  tb_checker chk_i (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic iload_write(input int addr, input logic [63:0] data);
    iload_req_i   <= 1'b1;
    iload_we_i    <= 1'b1;
    iload_addr_i  <= instr_addr_t'(addr);
    iload_be_i    <= 8'hff;
    iload_wdata_i <= data;
    @(posedge clk);
    iload_req_i <= 1'b0;
    iload_we_i  <= 1'b0;
  endtask

  task automatic dload_access(input int addr, input logic we, input logic [63:0] data);
    dload_req_i   <= 1'b1;
    dload_we_i    <= we;
    dload_addr_i  <= data_addr_t'(addr);
    dload_be_i    <= 8'hff;
    dload_wdata_i <= data;
    @(posedge clk);
    dload_req_i <= 1'b0;
    dload_we_i  <= 1'b0;
  endtask

  // waits for the grant and then for the response
  task automatic lsu_finish();
    while (!lsu_gnt_o) @(posedge clk);
    lsu_req_i <= 1'b0;
    lsu_we_i  <= 1'b0;
    do @(posedge clk); while (!lsu_rvalid_o);
  endtask

  task automatic lsu_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata);
    lsu_req_i   <= 1'b1;
    lsu_addr_i  <= addr;
    lsu_we_i    <= we;
    lsu_be_i    <= be;
    lsu_wdata_i <= wdata;
    @(posedge clk);
    lsu_finish();
  endtask

  // external slave with a random grant delay and a reply 1 to 3 cycles later
  int rsp_state, rsp_cnt;
  logic [31:0] rsp_data;
  always @(posedge clk) begin
    logic [31:0] d;
    if (!rst_n) begin
      rsp_state = 0;
    end else begin
      case (rsp_state)
        0: if (ext_req_o) begin
          rand_bits(2, d);
          rsp_cnt   = int'(d);
          rsp_state = 1;
        end
        1: if (rsp_cnt == 0) begin
          ext_gnt_i <= 1'b1;
          rsp_state = 2;
        end else begin
          rsp_cnt--;
        end
        2: begin
          ext_gnt_i <= 1'b0;
          rsp_data  = ~ext_addr_o;
          rand_bits(2, d);
          rsp_cnt   = int'(d % 3) + 1;
          rsp_state = 3;
        end
        3: if (rsp_cnt == 1) begin
          ext_rvalid_i <= 1'b1;
          ext_rdata_i  <= rsp_data;
          rsp_state = 4;
        end else begin
          rsp_cnt--;
        end
        default: begin
          ext_rvalid_i <= 1'b0;
          rsp_state = 0;
        end
      endcase
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    lfsr_q = LFSR_SEED;
    cycle_cnt = 0;
    rst_n = 1'b0;
    {fetch_req_i, lsu_req_i, lsu_we_i, iload_req_i, iload_we_i} = '0;
    {dload_req_i, dload_we_i, ext_gnt_i, ext_rvalid_i} = '0;
    {fetch_addr_i, lsu_addr_i, lsu_wdata_i, ext_rdata_i, irq_i} = '0;
    {lsu_be_i, iload_be_i, dload_be_i, iload_addr_i, dload_addr_i} = '0;
    {iload_wdata_i, dload_wdata_i} = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);

    // instruction loader fill then back-to-back fetches
    for (int i = 0; i < FETCH_WORDS; i++) begin
      rand_bits(32, r);
      rand_bits(32, a);
      iload_write(i * 8, {r, a});
    end
    for (int i = 0; i < 2 * FETCH_WORDS; i++) begin
      fetch_req_i  <= 1'b1;
      fetch_addr_i <= i * 4;
      do @(posedge clk); while (!fetch_gnt_o);
    end
    fetch_req_i <= 1'b0;
    repeat (2) @(posedge clk);

    // loader writes into the data RAM then core reads and masked writes
    for (int i = 0; i < 8; i++) begin
      rand_bits(32, r);
      rand_bits(32, a);
      dload_access(i * 8, 1'b1, {r, a});
    end
    for (int i = 0; i < 16; i++) begin
      lsu_access(LOCAL_BASE + i * 4, 1'b0, 4'h0, '0);
    end
    for (int i = 0; i < LSU_OPS; i++) begin
      rand_bits(4, a);
      rand_bits(5, r);
      rand_bits(32, w);
      lsu_access(LOCAL_BASE + a * 4, r[4], r[3:0], w);
    end
    for (int i = 0; i < 8; i++) begin
      dload_access(i * 8, 1'b0, '0);
    end
    @(posedge clk);

    // external requests under random back-pressure
    for (int i = 0; i < EXT_OPS; i++) begin
      rand_bits(32, a);
      if (a[31:20] == LOCAL_PAGE) begin
        a[31] = ~a[31];
      end
      rand_bits(5, r);
      rand_bits(32, w);
      lsu_access(a, r[4], r[3:0], w);
    end

    // loader and core requesting in the same cycle
    rand_bits(32, r);
    dload_req_i   <= 1'b1;
    dload_we_i    <= 1'b1;
    dload_addr_i  <= '0;
    dload_be_i    <= 8'hff;
    dload_wdata_i <= {r, ~r};
    lsu_req_i     <= 1'b1;
    lsu_addr_i    <= LOCAL_BASE + 4;
    lsu_we_i      <= 1'b0;
    iload_req_i   <= 1'b1;
    iload_we_i    <= 1'b1;
    iload_addr_i  <= 15'h8;
    iload_be_i    <= 8'hff;
    iload_wdata_i <= {~r, r};
    fetch_req_i   <= 1'b1;
    fetch_addr_i  <= 32'hc;
    @(posedge clk);
    {dload_req_i, dload_we_i, iload_req_i, iload_we_i} <= '0;
    while (!fetch_gnt_o) @(posedge clk);
    fetch_req_i <= 1'b0;
    lsu_finish();
    @(posedge clk);

    // random interrupt lines
    for (int i = 0; i < IRQ_CYCLES; i++) begin
      rand_bits(32, r);
      rand_bits(32, a);
      irq_i <= (i % 8 == 0) ? 32'h0 : (r & a);
      @(posedge clk);
    end
    irq_i <= '0;
    repeat (2) @(posedge clk);

    $display("errors: %0d data, %0d protocol", data_errs, proto_errs);
    if (data_errs + proto_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: core_mem_region.f
core_mem_pkg.sv
irq_id_encoder.sv
sp_ram.sv
ram_port_mux.sv
lsu_demux.sv
core_mem_region.sv
ram_port_mux_props.sv
tb_checker.sv
tb_core_mem_region.sv

// File: Makefile
# Verilator build and run for the core memory region testbench

TOP := tb_core_mem_region

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f core_mem_region.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
